// ==== src/aluOpsPkg.sv ====
`default_nettype none

package aluOpsPkg;

    localparam int aluOpWidth = 5;

    // Codes follow the opcode field of the instruction word
    typedef enum logic [aluOpWidth-1:0] {
        aluAdd  = 5'b00010,
        aluSub  = 5'b00011,
        aluAnd  = 5'b00100,
        aluOr   = 5'b00101,
        aluRor  = 5'b00110,
        aluRol  = 5'b00111,
        aluShr  = 5'b01000,
        aluShra = 5'b01001,
        aluShl  = 5'b01010,
        aluMul  = 5'b01110, // 64-bit signed product
        aluDiv  = 5'b01111, // Remainder high, quotient low
        aluNeg  = 5'b10000,
        aluNot  = 5'b10001,
        aluNop  = 5'b11010  // Idle value of the sequencer
    } aluOp;

endpackage

`default_nettype wire

// ==== src/datapathPkg.sv ====
`default_nettype none

package datapathPkg;
    import aluOpsPkg::*;

    localparam int wordWidth   = 32;
    localparam int regSelWidth = 4;
    localparam int opcodeWidth = 5;
    localparam int constWidth  = wordWidth - opcodeWidth - 2 * regSelWidth; // 19 bits

    // One control word per clock from the sequencer
    typedef struct packed {
        logic gra;       // Register picked by ra
        logic grb;       // By rb
        logic grc;       // By rc
        logic rIn;
        logic rOut;
        logic baOut;     // R0 reads as zero
        logic hiIn;
        logic hiOut;
        logic loIn;
        logic loOut;
        logic pcIn;
        logic pcOut;
        logic incPc;
        logic irIn;
        logic marIn;
        logic mdrIn;
        logic mdrOut;
        logic read;      // MDR takes memory data
        logic yIn;
        logic zIn;
        logic zHighOut;
        logic zLowOut;
        logic inPortOut;
        logic cOut;
        aluOp op;
    } controlWord;

    typedef struct packed {
        logic [opcodeWidth-1:0]            opcode;
        logic [regSelWidth-1:0]            ra;
        logic [regSelWidth-1:0]            rb;
        logic [regSelWidth-1:0]            rc;
        logic [constWidth-regSelWidth-1:0] spare;
    } registerForm;

    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [regSelWidth-1:0] ra;
        logic [regSelWidth-1:0] rb;
        logic [constWidth-1:0]  c;
    } immediateForm;

    // Same IR bits, two decodings
    typedef union packed {
        registerForm  rForm;
        immediateForm iForm;
    } instruction;

    // Every value that can drive the bus
    typedef struct packed {
        logic [wordWidth-1:0] general;
        logic [wordWidth-1:0] hi;
        logic [wordWidth-1:0] lo;
        logic [wordWidth-1:0] zHigh;
        logic [wordWidth-1:0] zLow;
        logic [wordWidth-1:0] pc;
        logic [wordWidth-1:0] mdr;
        logic [wordWidth-1:0] inPort;
        logic [wordWidth-1:0] c;
    } busSources;

endpackage

`default_nettype wire

// ==== src/registerBank.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerBank
    import datapathPkg::*;
(
    input  logic                 clock,
    input  logic                 rstN,
    input  controlWord           ctrl,
    input  instruction           ir,
    input  logic [wordWidth-1:0] bus,
    output busSources            sources
);

    localparam int regCount = 2 ** regSelWidth;

    logic [wordWidth-1:0]   regs [regCount];
    logic [wordWidth-1:0]   hi;
    logic [wordWidth-1:0]   lo;
    logic [regSelWidth-1:0] regSel;

    // Register number comes from the IR field named by the strobe
    always_comb begin
        if (ctrl.gra) begin
            regSel = ir.rForm.ra;
        end else if (ctrl.grb) begin
            regSel = ir.rForm.rb;
        end else if (ctrl.grc) begin
            regSel = ir.rForm.rc;
        end else begin
            regSel = '0;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.rIn) begin
            regs[regSel] <= bus;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (ctrl.hiIn) hi <= bus; // Usually Z high after mul or div
            if (ctrl.loIn) lo <= bus;
        end
    end

    always_comb begin
        sources = '0; // Special register fields stay clear on this side
        // Base address forming treats R0 as zero
        if (ctrl.baOut && regSel == '0) begin
            sources.general = '0;
        end else begin
            sources.general = regs[regSel];
        end
        sources.hi = hi;
        sources.lo = lo;
    end

    // Sequencer names at most one IR field per cycle
    gprSelectOne: assert property (@(posedge clock) disable iff (!rstN)
        $onehot0({ctrl.gra, ctrl.grb, ctrl.grc}));

endmodule

`default_nettype wire

// ==== src/specialRegisters.sv ====
`timescale 1ns/1ns
`default_nettype none

module specialRegisters
    import datapathPkg::*;
(
    input  logic                   clock,
    input  logic                   rstN,
    input  controlWord             ctrl,
    input  logic [wordWidth-1:0]   bus,
    input  logic [wordWidth-1:0]   mdataIn,
    input  logic [wordWidth-1:0]   inPort,
    input  logic [2*wordWidth-1:0] aluResult,
    output logic [wordWidth-1:0]   yValue,
    output instruction             ir,
    output busSources              sources
);

    logic [wordWidth-1:0]   pc;
    logic [wordWidth-1:0]   mar;
    logic [wordWidth-1:0]   mdr;
    logic [wordWidth-1:0]   y;
    logic [2*wordWidth-1:0] z;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc  <= '0;
            ir  <= '0;
            mar <= '0;
            y   <= '0;
        end else begin
            if (ctrl.pcIn) pc <= bus;
            if (ctrl.irIn) ir <= bus;
            if (ctrl.marIn) mar <= bus;
            if (ctrl.yIn) y <= bus; // First ALU operand
        end
    end

    // Memory side or bus side
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            mdr <= '0;
        end else if (ctrl.mdrIn) begin
            mdr <= ctrl.read ? mdataIn : bus;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            z <= '0;
        end else if (ctrl.zIn) begin
            // T0 fetch uses Z to hold the next PC
            z <= ctrl.incPc ? {{wordWidth{1'b0}}, pc + 1'b1} : aluResult;
        end
    end

    assign yValue = y;

    always_comb begin
        sources = '0; // General, HI and LO come from the bank
        sources.zHigh  = z[2*wordWidth-1:wordWidth];
        sources.zLow   = z[wordWidth-1:0];
        sources.pc     = pc;
        sources.mdr    = mdr;
        sources.inPort = inPort;
        // Sign-extended constant of the immediate form
        sources.c = {{(wordWidth - constWidth){ir.iForm.c[constWidth-1]}}, ir.iForm.c};
    end

    // PC+1 parked in Z must not race a direct PC load, and the
    // following PC load takes it back from Z low
    pcUpdatePath: assert property (@(posedge clock) disable iff (!rstN)
        (ctrl.incPc && ctrl.zIn) |-> !ctrl.pcIn ##1 (!ctrl.pcIn || ctrl.zLowOut));

    // Address settles in MAR a cycle before the read
    marBeforeRead: assert property (@(posedge clock) disable iff (!rstN)
        (ctrl.read && ctrl.mdrIn) |-> !ctrl.marIn && !$isunknown(mar));

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu
    import aluOpsPkg::*;
    import datapathPkg::*;
(
    input  logic [wordWidth-1:0]   y,
    input  logic [wordWidth-1:0]   b,
    input  aluOp                   op,
    output logic [2*wordWidth-1:0] result
);

    logic [4:0]                    shiftAmount;
    logic [2*wordWidth-1:0]        doubled;
    logic signed [2*wordWidth-1:0] product;
    logic signed [wordWidth-1:0]   quotient;
    logic signed [wordWidth-1:0]   remainder;

    assign shiftAmount = b[4:0];   // Only the low five bits count
    assign doubled     = {y, y};   // Rotates are windows into this

    // Signed operands extend to the full 64-bit product
    assign product = $signed(y) * $signed(b);

    always_comb begin
        if (b == '0) begin
            // Divide by zero gives zero in both halves
            quotient  = '0;
            remainder = '0;
        end else begin
            quotient  = $signed(y) / $signed(b);
            remainder = $signed(y) % $signed(b);
        end
    end

    always_comb begin
        result = '0; // High half stays zero for one-word results
        case (op)
            aluAdd: begin
                result[wordWidth-1:0] = y + b;
            end
            aluSub: begin
                result[wordWidth-1:0] = y - b;
            end
            aluAnd: begin
                result[wordWidth-1:0] = y & b;
            end
            aluOr: begin
                result[wordWidth-1:0] = y | b;
            end
            aluShr: begin
                result[wordWidth-1:0] = y >> shiftAmount;
            end
            aluShra: begin
                result[wordWidth-1:0] = $signed(y) >>> shiftAmount;
            end
            aluShl: begin
                result[wordWidth-1:0] = y << shiftAmount;
            end
            aluRor: begin
                result[wordWidth-1:0] = doubled[shiftAmount +: wordWidth];
            end
            aluRol: begin
                result[wordWidth-1:0] = doubled[(wordWidth - shiftAmount) +: wordWidth];
            end
            aluMul: begin
                result = product;
            end
            aluDiv: begin
                result = {remainder, quotient};
            end
            aluNeg: begin
                result[wordWidth-1:0] = -b;
            end
            aluNot: begin
                result[wordWidth-1:0] = ~b;
            end
            default: begin
                result = '0; // nop and unused codes
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/busEncoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module busEncoder
    import datapathPkg::*;
(
    input  logic                 clock,
    input  controlWord           ctrl,
    input  busSources            sources,
    output logic [wordWidth-1:0] bus
);

    logic generalOut;

    assign generalOut = ctrl.rOut | ctrl.baOut;

    // AND-OR select, zero when nothing drives
    always_comb begin
        bus = '0;
        bus |= {wordWidth{generalOut}}     & sources.general;
        bus |= {wordWidth{ctrl.hiOut}}     & sources.hi;
        bus |= {wordWidth{ctrl.loOut}}     & sources.lo;
        bus |= {wordWidth{ctrl.zHighOut}}  & sources.zHigh;
        bus |= {wordWidth{ctrl.zLowOut}}   & sources.zLow;
        bus |= {wordWidth{ctrl.pcOut}}     & sources.pc;
        bus |= {wordWidth{ctrl.mdrOut}}    & sources.mdr;
        bus |= {wordWidth{ctrl.inPortOut}} & sources.inPort;
        bus |= {wordWidth{ctrl.cOut}}      & sources.c;
    end

    // Two drivers at once would OR their values together
    singleDriver: assert property (@(posedge clock)
        $onehot0({ctrl.rOut, ctrl.baOut, ctrl.hiOut, ctrl.loOut, ctrl.zHighOut,
                  ctrl.zLowOut, ctrl.pcOut, ctrl.mdrOut, ctrl.inPortOut, ctrl.cOut}));

endmodule

`default_nettype wire

// ==== src/datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module datapath
    import datapathPkg::*;
(
    input  logic                 clock,
    input  logic                 rstN,
    input  controlWord           ctrl,
    input  logic [wordWidth-1:0] mdataIn,
    input  logic [wordWidth-1:0] inPort,
    output logic [wordWidth-1:0] bus
);

    instruction             irValue;
    logic [wordWidth-1:0]   yValue;
    logic [2*wordWidth-1:0] aluResult;
    busSources              bankSources;
    busSources              specialSources;
    busSources              sources;

    // Each side leaves the other side's fields at zero
    assign sources = bankSources | specialSources;

    registerBank regBank_i (
        .clock   (clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .ir      (irValue),
        .bus     (bus),
        .sources (bankSources)
    );

    specialRegisters specialRegs_i (
        .clock     (clock),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .bus       (bus),
        .mdataIn   (mdataIn),
        .inPort    (inPort),
        .aluResult (aluResult),
        .yValue    (yValue),
        .ir        (irValue),
        .sources   (specialSources)
    );

    alu alu_i (
        .y      (yValue),
        .b      (bus),     // Second operand straight off the bus
        .op     (ctrl.op),
        .result (aluResult)
    );

    busEncoder busEncoder_i (
        .clock   (clock),
        .ctrl    (ctrl),
        .sources (sources),
        .bus     (bus)
    );

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
    parameter int period      = 100,
    parameter int resetCycles = 4
) (
    output logic clock,
    output logic rstN
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    // Release falls in the low phase, clear of both edges
    initial begin
        rstN = 1'b0;
        #(resetCycles * period + period / 4);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/datapathTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module datapathTb
    import aluOpsPkg::*;
    import datapathPkg::*;
();

    localparam int clockPeriod = 100;
    localparam int resetCycles = 4;
    localparam int raField     = 0;
    localparam int rbField     = 1;
    localparam int rcField     = 2;
    localparam logic [wordWidth-1:0] inPortValue = 32'hA5A5_0F0F;

    // One row is one clock of sequencer output
    typedef struct packed {
        controlWord           ctrl;
        logic [wordWidth-1:0] mdata;
        logic [wordWidth-1:0] expected;
        logic                 check;    // Bus compared on this row
    } tableRow;

    logic                 clock;
    logic                 rstN;
    controlWord           ctrl;
    logic [wordWidth-1:0] mdataIn;
    logic [wordWidth-1:0] inPort;
    logic [wordWidth-1:0] bus;

    tableRow     rows[$];
    logic [31:0] lfsrState  = 32'h9119;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    clockGen #(.period(clockPeriod), .resetCycles(resetCycles)) clockGen_i (
        .clock (clock),
        .rstN  (rstN)
    );

    datapath dut_i (
        .clock   (clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .mdataIn (mdataIn),
        .inPort  (inPort),
        .bus     (bus)
    );

    // Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic randomWord(output logic [31:0] value);
        value = '0;
        for (int i = 0; i < 32; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    // Expected 64-bit Z for each operation
    function automatic logic [63:0] aluRule(aluOp op, logic [31:0] y, logic [31:0] b);
        logic [4:0]  s;
        logic [31:0] fill;
        logic [31:0] yMag;
        logic [31:0] bMag;
        logic [31:0] quotient;
        logic [31:0] remainder;
        s = b[4:0];
        fill = y[31] ? ~(32'hFFFF_FFFF >> s) : 32'h0; // Sign bits shifted in by shra
        yMag = y[31] ? -y : y;
        bMag = b[31] ? -b : b;
        case (op)
            aluAdd:  return {32'h0, y + b};
            aluSub:  return {32'h0, y - b};
            aluAnd:  return {32'h0, y & b};
            aluOr:   return {32'h0, y | b};
            aluShr:  return {32'h0, y >> s};
            aluShra: return {32'h0, (y >> s) | fill};
            aluShl:  return {32'h0, y << s};
            aluRor:  return {32'h0, (y >> s) | (y << (32 - s))};
            aluRol:  return {32'h0, (y << s) | (y >> (32 - s))};
            aluMul:  return {{32{y[31]}}, y} * {{32{b[31]}}, b};
            aluNeg:  return {32'h0, -b};
            aluNot:  return {32'h0, ~b};
            aluDiv: begin
                // Magnitudes divide, then the signs go back on
                quotient = yMag / bMag;
                remainder = yMag % bMag;
                if (y[31] ^ b[31]) quotient = -quotient;
                if (y[31]) remainder = -remainder; // Remainder follows the dividend
                return {remainder, quotient};
            end
            default: return 64'h0;
        endcase
    endfunction

    function automatic logic [31:0] instrWord(logic [4:0] opcode, logic [3:0] ra,
                                              logic [3:0] rb, logic [3:0] rc);
        return {opcode, ra, rb, rc, 15'h0};
    endfunction

    task automatic compareValue(string name, int row, logic [31:0] actual,
                                logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s at row %0d: got 0x%h, expected 0x%h",
                     name, row, actual, expected);
        end
    endtask

    task automatic addRow(controlWord c, logic [31:0] mdata, logic [31:0] expected,
                          logic check);
        rows.push_back(tableRow'{c, mdata, expected, check});
    endtask

    task automatic memRead(logic [31:0] value);
        addRow(controlWord'{mdrIn: 1'b1, read: 1'b1, op: aluNop, default: '0}, value, '0, 1'b0);
    endtask

    task automatic loadIr(logic [31:0] word);
        memRead(word);
        addRow(controlWord'{mdrOut: 1'b1, irIn: 1'b1, op: aluNop, default: '0}, '0, word, 1'b1);
    endtask

    task automatic loadReg(int field, logic [31:0] value);
        memRead(value);
        addRow(controlWord'{gra: field == raField, grb: field == rbField, grc: field == rcField,
                            mdrOut: 1'b1, rIn: 1'b1, op: aluNop, default: '0}, '0, value, 1'b1);
    endtask

    task automatic readReg(int field, logic [31:0] expected);
        addRow(controlWord'{gra: field == raField, grb: field == rbField, grc: field == rcField,
                            rOut: 1'b1, op: aluNop, default: '0}, '0, expected, 1'b1);
    endtask

    task automatic resetReads();
        addRow(controlWord'{rOut: 1'b1, op: aluNop, default: '0}, '0, '0, 1'b1);
        addRow(controlWord'{baOut: 1'b1, op: aluNop, default: '0}, '0, '0, 1'b1);
        addRow(controlWord'{hiOut: 1'b1, op: aluNop, default: '0}, '0, '0, 1'b1);
        addRow(controlWord'{loOut: 1'b1, op: aluNop, default: '0}, '0, '0, 1'b1);
        addRow(controlWord'{zHighOut: 1'b1, op: aluNop, default: '0}, '0, '0, 1'b1);
        addRow(controlWord'{zLowOut: 1'b1, op: aluNop, default: '0}, '0, '0, 1'b1);
        addRow(controlWord'{pcOut: 1'b1, op: aluNop, default: '0}, '0, '0, 1'b1);
        addRow(controlWord'{mdrOut: 1'b1, op: aluNop, default: '0}, '0, '0, 1'b1);
        addRow(controlWord'{cOut: 1'b1, op: aluNop, default: '0}, '0, '0, 1'b1);
        // Input pin, not a register
        addRow(controlWord'{inPortOut: 1'b1, op: aluNop, default: '0}, '0, inPortValue, 1'b1);
    endtask

    task automatic roundTrip(int field, logic [3:0] regNum);
        logic [31:0] value;
        randomWord(value);
        loadIr(instrWord(aluNop, field == raField ? regNum : 4'h0,
                         field == rbField ? regNum : 4'h0, field == rcField ? regNum : 4'h0));
        loadReg(field, value);
        readReg(field, value);
    endtask

    // R1 = R2 op R3 over steps T3 to T5
    task automatic runRandomOp(aluOp op);
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] expected;
        randomWord(a);
        randomWord(b);
        if (op == aluDiv && b == '0) begin
            b = 32'h1; // Divide by zero has no rule
        end
        expected = aluRule(op, a, b);
        loadIr(instrWord(op, 4'd1, 4'd2, 4'd3));
        loadReg(rbField, a);
        loadReg(rcField, b);
        addRow(controlWord'{grb: 1'b1, rOut: 1'b1, yIn: 1'b1, op: aluNop, default: '0}, '0, a, 1'b1);
        addRow(controlWord'{grc: 1'b1, rOut: 1'b1, zIn: 1'b1, op: op, default: '0}, '0, b, 1'b1);
        if (op == aluMul || op == aluDiv) begin
            addRow(controlWord'{zHighOut: 1'b1, hiIn: 1'b1, op: aluNop, default: '0}, '0,
                   expected[63:32], 1'b1);
            addRow(controlWord'{zLowOut: 1'b1, loIn: 1'b1, op: aluNop, default: '0}, '0,
                   expected[31:0], 1'b1);
            addRow(controlWord'{hiOut: 1'b1, op: aluNop, default: '0}, '0, expected[63:32], 1'b1);
            addRow(controlWord'{loOut: 1'b1, op: aluNop, default: '0}, '0, expected[31:0], 1'b1);
        end else begin
            addRow(controlWord'{zHighOut: 1'b1, op: aluNop, default: '0}, '0, '0, 1'b1);
            addRow(controlWord'{zLowOut: 1'b1, gra: 1'b1, rIn: 1'b1, op: aluNop, default: '0}, '0,
                   expected[31:0], 1'b1);
            readReg(raField, expected[31:0]);
        end
    endtask

    // T0 parks PC+1 in Z and the next cycle moves it back to PC
    task automatic fetchStep(logic [31:0] startPc);
        memRead(startPc);
        addRow(controlWord'{mdrOut: 1'b1, pcIn: 1'b1, op: aluNop, default: '0}, '0, startPc, 1'b1);
        addRow(controlWord'{pcOut: 1'b1, marIn: 1'b1, incPc: 1'b1, zIn: 1'b1, op: aluNop,
                            default: '0}, '0, startPc, 1'b1);
        addRow(controlWord'{zLowOut: 1'b1, pcIn: 1'b1, op: aluNop, default: '0}, '0,
               startPc + 32'h1, 1'b1);
        addRow(controlWord'{pcOut: 1'b1, op: aluNop, default: '0}, '0, startPc + 32'h1, 1'b1);
    endtask

    task automatic immediateAndBase(logic [18:0] c, logic [31:0] r0Value);
        loadIr({aluAdd, 4'h0, 4'h0, c}); // Immediate form with ra = R0
        addRow(controlWord'{cOut: 1'b1, op: aluNop, default: '0}, '0, {{13{c[18]}}, c}, 1'b1);
        loadReg(raField, r0Value);
        readReg(raField, r0Value);
        addRow(controlWord'{gra: 1'b1, baOut: 1'b1, op: aluNop, default: '0}, '0, '0, 1'b1);
    endtask

    initial begin
        ctrl = controlWord'{op: aluNop, default: '0};
        mdataIn = '0;
        inPort = inPortValue;
        resetReads();
        roundTrip(raField, 4'd5);
        roundTrip(rbField, 4'd10);
        roundTrip(rcField, 4'd15);
        runRandomOp(aluAdd);
        runRandomOp(aluSub);
        runRandomOp(aluAnd);
        runRandomOp(aluOr);
        runRandomOp(aluShr);
        runRandomOp(aluShra);
        runRandomOp(aluShl);
        runRandomOp(aluRor);
        runRandomOp(aluRol);
        runRandomOp(aluNeg);
        runRandomOp(aluNot);
        runRandomOp(aluMul);
        runRandomOp(aluMul);
        runRandomOp(aluDiv);
        runRandomOp(aluDiv);
        fetchStep(32'h0000_00FF);
        fetchStep(32'hFFFF_FFFF);           // Wraps to zero
        immediateAndBase(19'h7FFF0, 32'h1234_5678);
        immediateAndBase(19'h12345, 32'h8000_0001);
        cycleLimit = rows.size() + resetCycles + 20;

        wait (rstN === 1'b1);
        foreach (rows[i]) begin
            @(negedge clock);
            ctrl = rows[i].ctrl;
            mdataIn = rows[i].mdata;
            #(clockPeriod / 4);             // Bus settled before the rising edge
            if (rows[i].check) begin
                compareValue("bus", i, bus, rows[i].expected);
            end
        end
        @(negedge clock);
        ctrl = controlWord'{op: aluNop, default: '0};

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            $display("Some tests failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/aluOpsPkg.sv
src/datapathPkg.sv
src/registerBank.sv
src/specialRegisters.sv
src/alu.sv
src/busEncoder.sv
src/datapath.sv
verification/clockGen.sv
verification/datapathTb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run datapathTb, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -f build.f --top-module datapathTb -o datapathSim
	./obj_dir/datapathSim | tee sim.log
	grep -qx "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
